/* bu_stimulus.txt */
# pc insn op_a op_b predict | expected taken flush cacheflush update nxt_pc (hex)
# Branches +16 or -8, JAL +0x100/-4/+0x102, JALR target op_a+op_b with bit 0 cleared
00001000 00208863 00000005 00000005 2 1 0 0 1 00001010
00001000 00208863 00000005 00000006 2 0 1 0 1 00001004
00001000 00209863 00000007 00000008 0 1 1 0 1 00001010
00001000 00209863 00000009 00000009 1 0 0 0 1 00001004
00001000 0020c863 ffffffff 00000001 3 1 0 0 1 00001010
00001000 0020c863 00000001 ffffffff 2 0 1 0 1 00001004
00001000 0020d863 80000000 7fffffff 0 0 0 0 1 00001004
00001000 0020d863 00000005 00000005 0 1 1 0 1 00001010
00001000 0020e863 00000001 ffffffff 0 1 1 0 1 00001010
00001000 0020e863 ffffffff 00000001 0 0 0 0 1 00001004
00001000 0020f863 80000000 7fffffff 2 1 0 0 1 00001010
00001000 0020f863 00000000 00000001 3 0 1 0 1 00001004
00001000 fe20cce3 80000000 00000000 2 1 0 0 1 00000ff8
00001000 fe20dce3 7fffffff 80000000 0 1 1 0 1 00000ff8
00002000 100000ef 00000000 00000000 2 1 0 0 0 00002100
00002000 100000ef 00000000 00000000 0 1 1 0 0 00002100
00002000 ffdff0ef 00000000 00000000 0 1 1 0 0 00001ffc
00002000 102000ef 00000000 00000000 2 1 0 0 0 00002102
00003000 000100e7 00003000 00000011 0 1 1 0 0 00003010
00003000 000100e7 00004001 00000004 2 1 1 0 0 00004004
00005000 0000100f 00000000 00000000 0 0 1 1 0 00005004
00006000 00000013 00000001 00000002 0 0 0 0 0 00006004
00006004 0000000f 00000000 00000000 0 0 0 0 0 00006008

/* sources.f */
rv_isa_pkg.sv
bu_state_pkg.sv
bu_operand_stage.sv
branch_resolve.sv
branch_commit.sv
branch_unit_top.sv
tb_branch_unit.sv

/* Makefile */
# Verilator build, run, lint and clean for the branch unit

TOP := tb_branch_unit

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module $(TOP) -f sources.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^Done: no errors$$'

lint:
	verilator --lint-only --timing --timescale 1ns/1ps \
	  --top-module branch_unit_top -f sources.f

clean:
	rm -rf obj_dir

/* tb_branch_unit.sv */
////////////////////////////////////////////////////////////
// Branch unit testbench with file vectors, stall, history
// and exception kill checks against expected values
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_branch_unit;

  localparam int          HIST_BITS = 2;
  localparam logic [31:0] PC_RESET  = 32'h200;
  localparam int          WAIT_MAX  = 20;

  logic                      clk_i = 1'b0;
  logic                      rst_ni;
  logic                      ex_stall_i;
  logic                      st_flush_i;
  logic                      later_exc_any_i;
  bu_state_pkg::issue_slot_t slot_i;
  logic [31:0]               nxt_pc_o;
  logic                      flush_o;
  logic                      cacheflush_o;
  logic                      bp_taken_o;
  logic                      bp_update_o;
  logic [1:0]                bp_predict_o;
  logic [HIST_BITS-1:0]      bp_history_o;
  bu_state_pkg::exc_t        exc_o;

  int          errors;
  int          checks;
  bit          timed_out;
  // Reference history one bit longer than the output
  logic [HIST_BITS:0] hist_model;

  branch_unit_top dut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .ex_stall_i      (ex_stall_i),
    .st_flush_i      (st_flush_i),
    .later_exc_any_i (later_exc_any_i),
    .slot_i          (slot_i),
    .nxt_pc_o        (nxt_pc_o),
    .flush_o         (flush_o),
    .cacheflush_o    (cacheflush_o),
    .bp_taken_o      (bp_taken_o),
    .bp_update_o     (bp_update_o),
    .bp_predict_o    (bp_predict_o),
    .bp_history_o    (bp_history_o),
    .exc_o           (exc_o)
  );

  // 10 ns period
  always #5 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic drive_slot(input logic [31:0] pc, input logic [31:0] insn,
                            input logic [31:0] op_a, input logic [31:0] op_b,
                            input logic [1:0] pred);
    slot_i         = '0;
    slot_i.insn    = insn;
    slot_i.pc      = pc;
    slot_i.op_a    = op_a;
    slot_i.op_b    = op_b;
    slot_i.predict = pred;
  endtask

  task automatic drive_bubble();
    slot_i        = '0;
    slot_i.bubble = 1'b1;
  endtask

  // A pending flush would bubble the next slot and must drain first
  task automatic wait_flush_low(input string where);
    int cnt;
    cnt = 0;
    while (flush_o && cnt < WAIT_MAX) begin
      @(negedge clk_i);
      cnt++;
    end
    if (flush_o) begin
      errors++;
      timed_out = 1'b1;
      $display("Timeout: flush_o still high after %0d cycles (%s)", WAIT_MAX, where);
    end
  endtask

  // Shift model and compare the older bits
  task automatic track_history(input string tag, input logic update, input logic taken);
    if (update) begin
      hist_model = {hist_model[HIST_BITS-1:0], taken};
    end
    check({tag, " bp_history_o"}, 32'(hist_model[HIST_BITS:1]), 32'(bp_history_o));
  endtask

  ////////////////////////////////////////////////////////////
  // Vector flow with a slot and a bubble checked two edges later
  ////////////////////////////////////////////////////////////

  task automatic apply_vector(input string tag,
                              input logic [31:0] pc, insn, op_a, op_b, pred,
                              input logic [31:0] e_taken, e_flush, e_cflush,
                              input logic [31:0] e_update, e_pc);
    logic [6:0] opc;
    logic       mis;
    logic [2:0] e_exc;
    wait_flush_low(tag);
    if (timed_out) return;
    drive_slot(pc, insn, op_a, op_b, pred[1:0]);
    @(negedge clk_i);
    drive_bubble();
    @(negedge clk_i);
    // Jumps and branches trap on a target off the word grid
    opc   = insn[6:0];
    mis   = (opc == 7'h6f || opc == 7'h67 || opc == 7'h63) && (e_pc[1:0] != 2'b00);
    e_exc = {1'b0, mis, mis};
    check({tag, " bp_taken_o"}, e_taken, 32'(bp_taken_o));
    check({tag, " flush_o"}, e_flush, 32'(flush_o));
    check({tag, " cacheflush_o"}, e_cflush, 32'(cacheflush_o));
    check({tag, " bp_update_o"}, e_update, 32'(bp_update_o));
    check({tag, " nxt_pc_o"}, e_pc, nxt_pc_o);
    check({tag, " bp_predict_o"}, 32'(pred[1:0]), 32'(bp_predict_o));
    check({tag, " exc_o"}, 32'(e_exc), 32'(exc_o));
    track_history(tag, e_update[0], e_taken[0]);
  endtask

  task automatic run_vectors();
    int          fd;
    int          n;
    int          lineno;
    string       line;
    string       tag;
    logic [31:0] v [10];
    fd = $fopen("bu_stimulus.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the stimulus file bu_stimulus.txt");
      return;
    end
    lineno = 0;
    while (!$feof(fd) && !timed_out) begin
      line = "";
      n    = $fgets(line, fd);
      lineno++;
      // Skip empty and comment lines
      if (n > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                    v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9]);
        tag = $sformatf("line %0d", lineno);
        if (n != 10) begin
          errors++;
          $display("Stimulus line %0d has %0d fields instead of 10", lineno, n);
        end else begin
          apply_vector(tag, v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9]);
        end
      end
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////////////////////////
  // Directed cases
  ////////////////////////////////////////////////////////////

  task automatic run_stall();
    int          stall_len;
    int          flush_seen;
    int          update_seen;
    logic [31:0] held_pc;
    logic [1:0]  held_hist;
    stall_len = 1 + int'($urandom % 5);
    wait_flush_low("stall test");
    if (timed_out) return;
    // BNE +16 with different operands and predicted not taken
    drive_slot(32'h7000, 32'h0020_9863, 32'd1, 32'd2, 2'b00);
    @(negedge clk_i);
    // Branch now sits in the operand register
    drive_bubble();
    ex_stall_i  = 1'b1;
    held_pc     = nxt_pc_o;
    held_hist   = bp_history_o;
    flush_seen  = 0;
    update_seen = 0;
    repeat (stall_len) begin
      @(negedge clk_i);
      flush_seen  += int'(flush_o);
      update_seen += int'(bp_update_o);
      check("stall nxt_pc_o held", held_pc, nxt_pc_o);
      check("stall bp_history_o held", 32'(held_hist), 32'(bp_history_o));
    end
    ex_stall_i = 1'b0;
    @(negedge clk_i);
    check("stall release flush_o", 32'd1, 32'(flush_o));
    check("stall release bp_update_o", 32'd1, 32'(bp_update_o));
    check("stall release nxt_pc_o", 32'h7010, nxt_pc_o);
    flush_seen  += int'(flush_o);
    update_seen += int'(bp_update_o);
    track_history("stall release", 1'b1, 1'b1);
    @(negedge clk_i);
    flush_seen  += int'(flush_o);
    update_seen += int'(bp_update_o);
    check("stall flush_o pulse count", 32'd1, 32'(flush_seen));
    check("stall bp_update_o pulse count", 32'd1, 32'(update_seen));
  endtask

  // Misaligned JAL killed at its commit edge
  task automatic kill_case(input string name, input logic later_exc, input logic stage_flush);
    wait_flush_low(name);
    if (timed_out) return;
    // JAL +0x102 to a target ending in binary 10
    drive_slot(32'h2000, 32'h1020_00ef, 32'd0, 32'd0, 2'b10);
    @(negedge clk_i);
    drive_bubble();
    later_exc_any_i = later_exc;
    st_flush_i      = stage_flush;
    @(negedge clk_i);
    later_exc_any_i = 1'b0;
    st_flush_i      = 1'b0;
    check({name, " exc_o"}, 32'd0, 32'(exc_o));
    check({name, " nxt_pc_o"}, 32'h2102, nxt_pc_o);
  endtask

  task automatic run_tests();
    // Reset values with the startup flush still up
    check("reset flush_o high", 32'd1, 32'(flush_o));
    check("reset nxt_pc_o", PC_RESET, nxt_pc_o);
    check("reset cacheflush_o", 32'd0, 32'(cacheflush_o));
    check("reset exc_o", 32'd0, 32'(exc_o));
    @(negedge clk_i);
    check("flush_o after first edge", 32'd0, 32'(flush_o));
    run_vectors();
    if (!timed_out) run_stall();
    if (!timed_out) kill_case("kill by later exception", 1'b1, 1'b0);
    if (!timed_out) kill_case("kill by stage flush", 1'b0, 1'b1);
  endtask

  initial begin
    void'($urandom(75));
    errors          = 0;
    checks          = 0;
    timed_out       = 1'b0;
    hist_model      = '0;
    rst_ni          = 1'b0;
    ex_stall_i      = 1'b0;
    st_flush_i      = 1'b0;
    later_exc_any_i = 1'b0;
    drive_bubble();
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    run_tests();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* branch_unit_top.sv */
////////////////////////////////////////////////////////////
// Branch unit top: operand register, resolver, commit
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module branch_unit_top #(
  parameter logic [31:0] PC_INIT        = 32'h200,
  parameter int unsigned BP_GLOBAL_BITS = 2,
  parameter bit          HAS_RVC        = 1'b0
) (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      ex_stall_i,
  input  wire logic                      st_flush_i,
  // OR of execute, memory and writeback exception flags
  input  wire logic                      later_exc_any_i,
  input  wire bu_state_pkg::issue_slot_t slot_i,
  output logic [31:0]                    nxt_pc_o,
  output logic                           flush_o,
  output logic                           cacheflush_o,
  output logic                           bp_taken_o,
  output logic                           bp_update_o,
  output logic [1:0]                     bp_predict_o,
  output logic [BP_GLOBAL_BITS-1:0]      bp_history_o,
  output bu_state_pkg::exc_t             exc_o
);

  bu_state_pkg::issue_slot_t slot_q;
  bu_state_pkg::branch_res_t res;

  // Input side, bubbled by its own registered flush
  bu_operand_stage u_operand (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .ex_stall_i (ex_stall_i),
    .st_flush_i (st_flush_i),
    .flush_i    (flush_o),
    .slot_i     (slot_i),
    .slot_o     (slot_q)
  );

  // Zero-latency decision
  branch_resolve #(
    .HAS_RVC (HAS_RVC)
  ) u_resolve (
    .slot_i (slot_q),
    .res_o  (res)
  );

  // Output side, one edge after the operand register
  branch_commit #(
    .PC_INIT        (PC_INIT),
    .BP_GLOBAL_BITS (BP_GLOBAL_BITS)
  ) u_commit (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .ex_stall_i      (ex_stall_i),
    .st_flush_i      (st_flush_i),
    .later_exc_any_i (later_exc_any_i),
    .res_i           (res),
    .nxt_pc_o        (nxt_pc_o),
    .flush_o         (flush_o),
    .cacheflush_o    (cacheflush_o),
    .bp_taken_o      (bp_taken_o),
    .bp_update_o     (bp_update_o),
    .bp_predict_o    (bp_predict_o),
    .bp_history_o    (bp_history_o),
    .exc_o           (exc_o)
  );

endmodule

`default_nettype wire

/* branch_commit.sv */
////////////////////////////////////////////////////////////
// Output registers: next pc, flush pulses, predictor
// feedback, global history and exception record
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module branch_commit #(
  parameter logic [31:0] PC_INIT        = 32'h200,
  parameter int unsigned BP_GLOBAL_BITS = 2
) (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      ex_stall_i,
  input  wire logic                      st_flush_i,
  input  wire logic                      later_exc_any_i,
  input  wire bu_state_pkg::branch_res_t res_i,
  output logic [31:0]                    nxt_pc_o,
  output logic                           flush_o,
  output logic                           cacheflush_o,
  output logic                           bp_taken_o,
  output logic                           bp_update_o,
  output logic [1:0]                     bp_predict_o,
  output logic [BP_GLOBAL_BITS-1:0]      bp_history_o,
  output bu_state_pkg::exc_t             exc_o
);

  // One extra bit so the newest outcome can be left out
  logic [BP_GLOBAL_BITS:0] hist_q;
  logic                    exc_kill;

  ////////////////////////////////////////////////////////////
  // Pulses and predictor feedback
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // Startup flush so fetch begins at PC_INIT
      flush_o      <= 1'b1;
      cacheflush_o <= 1'b0;
      bp_taken_o   <= 1'b0;
      bp_update_o  <= 1'b0;
      bp_predict_o <= 2'b00;
    end else if (ex_stall_i) begin
      // Result already reported, keep pulses single
      flush_o      <= 1'b0;
      cacheflush_o <= 1'b0;
      bp_update_o  <= 1'b0;
    end else begin
      flush_o      <= res_i.pipeflush;
      cacheflush_o <= res_i.cacheflush;
      bp_taken_o   <= res_i.taken;
      bp_update_o  <= res_i.update;
      bp_predict_o <= res_i.predict;
    end
  end

  // Next pc and history freeze under stall
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nxt_pc_o <= PC_INIT;
      hist_q   <= '0;
    end else if (!ex_stall_i) begin
      nxt_pc_o <= res_i.nxt_pc;
      // Shift in the outcome of each conditional branch
      if (res_i.update) begin
        hist_q <= {hist_q[BP_GLOBAL_BITS-1:0], res_i.taken};
      end
    end
  end

  // Older outcomes only
  assign bp_history_o = hist_q[BP_GLOBAL_BITS:1];

  ////////////////////////////////////////////////////////////
  // Exception record
  ////////////////////////////////////////////////////////////

  // Own flush, outside flush or an older faulting instruction
  assign exc_kill = flush_o | st_flush_i | later_exc_any_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exc_o <= '0;
    end else if (!ex_stall_i) begin
      if (exc_kill) begin
        exc_o <= '0;
      end else begin
        exc_o <= res_i.exc;
      end
    end
  end

  // Predictor must not train twice on a held result
  a_no_update_after_stall: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ex_stall_i |=> !bp_update_o
  ) else $error("predictor update after a stalled edge");

endmodule

`default_nettype wire

/* branch_resolve.sv */
////////////////////////////////////////////////////////////
// Branch decision, target arithmetic, alignment check and
// flush decision for one issue slot
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module branch_resolve #(
  parameter bit HAS_RVC = 1'b0
) (
  input  wire bu_state_pkg::issue_slot_t slot_i,
  output bu_state_pkg::branch_res_t      res_o
);

  rv_isa_pkg::insn_word_t insn;
  logic [6:0]             opcode;
  logic [12:0]            imm_b_w;
  logic [20:0]            imm_j_w;
  logic [31:0]            ext_b;
  logic [31:0]            ext_j;
  logic [31:0]            fall_step;
  logic [31:0]            pc_fall;
  logic                   eq;
  logic                   lt_u;
  logic                   lt_s;
  logic                   br_cond;
  logic                   br_valid;
  logic                   taken;
  logic                   update;
  logic                   pipeflush;
  logic                   cacheflush;
  logic                   check_align;
  logic                   target_bad;
  logic                   misaligned;
  logic [31:0]            nxt_pc;

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////

  assign insn   = slot_i.insn;
  // Opcode field is shared by both views
  assign opcode = insn.btype.opcode;

  // Immediates sign extended to 32 bits
  assign imm_b_w = rv_isa_pkg::imm_b(insn);
  assign imm_j_w = rv_isa_pkg::imm_j(insn);
  assign ext_b   = {{19{imm_b_w[12]}}, imm_b_w};
  assign ext_j   = {{11{imm_j_w[20]}}, imm_j_w};

  // 16-bit encodings have bits 1:0 other than 11
  assign fall_step = (HAS_RVC && (opcode[1:0] != 2'b11)) ? 32'd2 : 32'd4;
  assign pc_fall   = slot_i.pc + fall_step;

  ////////////////////////////////////////////////////////////
  // Comparator
  ////////////////////////////////////////////////////////////

  assign eq   = (slot_i.op_a == slot_i.op_b);
  assign lt_u = (slot_i.op_a < slot_i.op_b);
  assign lt_s = ($signed(slot_i.op_a) < $signed(slot_i.op_b));

  // Condition by funct3 with reserved codes taken as no branch
  always_comb begin
    br_valid = 1'b1;
    case (insn.btype.funct3)
      rv_isa_pkg::F3_BEQ:  br_cond = eq;
      rv_isa_pkg::F3_BNE:  br_cond = ~eq;
      rv_isa_pkg::F3_BLT:  br_cond = lt_s;
      rv_isa_pkg::F3_BGE:  br_cond = ~lt_s;
      rv_isa_pkg::F3_BLTU: br_cond = lt_u;
      rv_isa_pkg::F3_BGEU: br_cond = ~lt_u;
      default: begin
        br_cond  = 1'b0;
        br_valid = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Outcome per instruction
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Default is plain fall-through without side effects
    taken       = 1'b0;
    update      = 1'b0;
    pipeflush   = 1'b0;
    cacheflush  = 1'b0;
    check_align = 1'b0;
    nxt_pc      = pc_fall;
    if (!slot_i.bubble) begin
      case (opcode)
        rv_isa_pkg::OPC_JAL: begin
          // Predicted jumps were already redirected by fetch
          taken       = 1'b1;
          pipeflush   = ~slot_i.predict[1];
          check_align = 1'b1;
          nxt_pc      = slot_i.pc + ext_j;
        end
        rv_isa_pkg::OPC_JALR: begin
          // Register target is never predicted
          taken       = 1'b1;
          pipeflush   = 1'b1;
          check_align = 1'b1;
          nxt_pc      = (slot_i.op_a + slot_i.op_b) & ~32'd1;
        end
        rv_isa_pkg::OPC_BRANCH: begin
          if (br_valid) begin
            taken       = br_cond;
            update      = 1'b1;
            // Mispredict in either direction
            pipeflush   = br_cond ^ slot_i.predict[1];
            check_align = 1'b1;
            nxt_pc      = br_cond ? slot_i.pc + ext_b : pc_fall;
          end
        end
        rv_isa_pkg::OPC_MISCMEM: begin
          // Only FENCE.I acts and other fences fall through
          if (insn == rv_isa_pkg::FENCE_I_WORD) begin
            pipeflush  = 1'b1;
            cacheflush = 1'b1;
            nxt_pc     = slot_i.pc + 32'd4;
          end
        end
        default: begin
          // Not a control transfer
          nxt_pc = pc_fall;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Misalignment and result
  ////////////////////////////////////////////////////////////

  // Half-word targets are legal only with compressed support
  assign target_bad = HAS_RVC ? nxt_pc[0] : |nxt_pc[1:0];
  assign misaligned = slot_i.exc.misaligned | (check_align & target_bad);

  always_comb begin
    res_o                = '0;
    res_o.taken          = taken;
    res_o.update         = update;
    res_o.pipeflush      = pipeflush;
    res_o.cacheflush     = cacheflush;
    res_o.nxt_pc         = nxt_pc;
    res_o.predict        = slot_i.predict;
    res_o.exc.illegal    = slot_i.exc.illegal;
    res_o.exc.misaligned = misaligned;
    // Summary flag rebuilt from the causes in this result
    res_o.exc.any        = slot_i.exc.illegal | misaligned;
  end

  // Refetch after a cache flush needs the pipe emptied too
  always_comb begin
    a_cacheflush_pipeflush: assert (!res_o.cacheflush || res_o.pipeflush)
      else $error("cache flush without pipeline flush");
  end

endmodule

`default_nettype wire

/* bu_operand_stage.sv */
////////////////////////////////////////////////////////////
// Input register of the branch unit holding the decode slot
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module bu_operand_stage (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      ex_stall_i,
  // External flush from a later stage
  input  wire logic                      st_flush_i,
  // Registered flush of this unit fed back
  input  wire logic                      flush_i,
  input  wire bu_state_pkg::issue_slot_t slot_i,
  output bu_state_pkg::issue_slot_t      slot_o
);

  ////////////////////////////////////////////////////////////
  // Slot register
  ////////////////////////////////////////////////////////////

  bu_state_pkg::issue_slot_t slot_q;
  logic                      kill;

  // Either flush turns the captured item into a bubble
  assign kill = st_flush_i | flush_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // Start out empty
      slot_q        <= '0;
      slot_q.bubble <= 1'b1;
    end else if (!ex_stall_i) begin
      if (kill) begin
        // Clean bubble so no stale exception or pc travels on
        slot_q        <= '0;
        slot_q.bubble <= 1'b1;
      end else begin
        slot_q <= slot_i;
      end
    end
    // Stall keeps the current slot for the resolver
  end

  assign slot_o = slot_q;

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Execute stall must freeze the whole slot including flushes
  a_hold_on_stall: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ex_stall_i |=> $stable(slot_o)
  ) else $error("operand slot changed during a stall");

endmodule

`default_nettype wire

/* bu_state_pkg.sv */
////////////////////////////////////////////////////////////
// Pipeline state records: exception flags, issue slot and
// branch resolution result
////////////////////////////////////////////////////////////

`default_nettype none

package bu_state_pkg;

  // Exception record carried along the pipe
  // any is the OR of the individual causes
  typedef struct packed {
    logic illegal;
    logic misaligned;
    logic any;
  } exc_t;

  ////////////////////////////////////////////////////////////
  // Decode-stage item handed to the branch unit
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    // No instruction in this slot
    logic                   bubble;
    rv_isa_pkg::insn_word_t insn;
    logic [31:0]            pc;
    // Register operands as read in decode
    logic [31:0]            op_a;
    logic [31:0]            op_b;
    // Static prediction, bit 1 means taken
    logic [1:0]             predict;
    exc_t                   exc;
  } issue_slot_t;

  ////////////////////////////////////////////////////////////
  // Outcome of one resolved slot
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic        taken;
    // Conditional branches only, feeds the predictor
    logic        update;
    logic        pipeflush;
    logic        cacheflush;
    logic [31:0] nxt_pc;
    // Prediction passed through for predictor training
    logic [1:0]  predict;
    exc_t        exc;
  } branch_res_t;

endpackage

`default_nettype wire

/* rv_isa_pkg.sv */
////////////////////////////////////////////////////////////
// RISC-V control-transfer opcodes and funct3 codes
// Instruction word views and immediate decode functions
////////////////////////////////////////////////////////////

`default_nettype none

package rv_isa_pkg;

  ////////////////////////////////////////////////////////////
  // Major opcodes, bits 6:0 of the instruction word
  ////////////////////////////////////////////////////////////
  localparam logic [6:0] OPC_JAL     = 7'b1101111;
  localparam logic [6:0] OPC_JALR    = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH  = 7'b1100011;
  localparam logic [6:0] OPC_MISCMEM = 7'b0001111;

  // Conditional branch funct3 codes
  // 010 and 011 are reserved
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // FENCE.I with all other fields zero
  localparam logic [31:0] FENCE_I_WORD = 32'h0000_100f;

  ////////////////////////////////////////////////////////////
  // Instruction word layouts
  ////////////////////////////////////////////////////////////

  // B-type, immediate bits scattered around rs1/rs2
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } btype_t;

  // J-type, 20-bit immediate in the upper part
  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } jtype_t;

  // One word, read either way; opcode sits in the same bits
  typedef union packed {
    btype_t btype;
    jtype_t jtype;
  } insn_word_t;

  // Branch offset, bit 0 always zero
  function automatic logic [12:0] imm_b(input insn_word_t w);
    return {w.btype.imm_12, w.btype.imm_11, w.btype.imm_10_5,
            w.btype.imm_4_1, 1'b0};
  endfunction

  // Jump offset, bit 0 always zero
  function automatic logic [20:0] imm_j(input insn_word_t w);
    return {w.jtype.imm_20, w.jtype.imm_19_12, w.jtype.imm_11,
            w.jtype.imm_10_1, 1'b0};
  endfunction

endpackage

`default_nettype wire
